// File: project.f
mhq_pkg.sv
mhq_entry.sv
mhq_lu.sv
mhq_ex.sv
mhq_fill.sv
mhq_top.sv
mhq_assertions.sv
mhq_tb.sv

// File: Makefile
# Verilator build and run for the MHQ testbench

VERILATOR ?= verilator
TOP       ?= mhq_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= ** FAIL **
PASS_MSG  ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -F -q -- '$(FAIL_MSG)' $(LOG) || \
	   ! grep -F -q -- '$(PASS_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: mhq_tb.sv
// ---------------------------------------------------------
// MHQ testbench: table driven lookups with a BIU line model
// ---------------------------------------------------------
`timescale 1ns/1ps

module mhq_tb;

    localparam int DEPTH      = 4;
    localparam int TAG_W      = $clog2(DEPTH);
    localparam int NUM_STEPS  = 26;
    localparam int CLK_PERIOD = 100;
    localparam int LA_W       = mhq_pkg::LINE_ADDR_WIDTH;
    localparam int LINE_W     = mhq_pkg::LINE_WIDTH;

    typedef struct packed {
        logic [2:0]         req;
        mhq_pkg::lsu_func_t func;
        logic [31:0]        addr;
        logic               biu;
        logic [3:0]         exp;
        logic [TAG_W-1:0]   tag;
    } step_t;

    logic                  clk;
    logic                  n_rst;
    mhq_pkg::lu_req_t      lu_req;
    mhq_pkg::lu_res_t      lu_res;
    logic [TAG_W-1:0]      lu_tag;
    logic                  biu_req;
    logic [LA_W-1:0]       biu_addr;
    mhq_pkg::biu_rsp_t     biu_rsp;
    mhq_pkg::fill_t        fill;

    step_t                 steps [NUM_STEPS];
    mhq_pkg::lu_res_t      exp_res;
    mhq_pkg::fill_t        exp_fill;
    logic [LA_W-1:0]       model_line [DEPTH];
    logic [LINE_W-1:0]     model_data [DEPTH];
    logic [15:0]           model_mask [DEPTH];
    int                    alloc_q [$];
    int                    errors;
    int                    errors_before;
    int                    failed_steps;

    mhq_top #(.MHQ_DEPTH(DEPTH)) mhq_top_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_lu_req   (lu_req),
        .o_lu_res   (lu_res),
        .o_lu_tag   (lu_tag),
        .o_biu_req  (biu_req),
        .o_biu_addr (biu_addr),
        .i_biu_rsp  (biu_rsp),
        .o_fill     (fill)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Columns: {valid, dc_hit, we}, func, address, BIU return,
    // expected {match, retry, replay, en}, expected tag
    task automatic load_steps();
        steps = '{
            '{3'b100, mhq_pkg::LW,   32'h0000_1000, 1'b0, 4'b0001, 2'd0},
            '{3'b101, mhq_pkg::SB,   32'h0000_1001, 1'b0, 4'b1001, 2'd0},
            '{3'b100, mhq_pkg::LB,   32'h0000_2000, 1'b0, 4'b0001, 2'd1},
            '{3'b101, mhq_pkg::SH,   32'h0000_1006, 1'b0, 4'b1001, 2'd0},
            '{3'b110, mhq_pkg::LW,   32'h0000_3000, 1'b0, 4'b0000, 2'd0},
            '{3'b100, mhq_pkg::FILL, 32'h0000_3000, 1'b0, 4'b0000, 2'd0},
            '{3'b101, mhq_pkg::SW,   32'h0000_100C, 1'b0, 4'b1001, 2'd0},
            '{3'b100, mhq_pkg::LW,   32'h0000_1000, 1'b1, 4'b1010, 2'd0},
            '{3'b101, mhq_pkg::SB,   32'h0000_1002, 1'b0, 4'b1010, 2'd0},
            '{3'b100, mhq_pkg::LW,   32'h0000_3000, 1'b0, 4'b0001, 2'd2},
            '{3'b100, mhq_pkg::LW,   32'h0000_4000, 1'b0, 4'b0001, 2'd3},
            '{3'b101, mhq_pkg::SW,   32'h0000_5004, 1'b0, 4'b0001, 2'd0},
            '{3'b100, mhq_pkg::LW,   32'h0000_6000, 1'b0, 4'b0100, 2'd0},
            '{3'b100, mhq_pkg::LH,   32'h0000_3002, 1'b0, 4'b1001, 2'd2},
            '{3'b101, mhq_pkg::SH,   32'h0000_5008, 1'b0, 4'b1001, 2'd0},
            '{3'b100, mhq_pkg::LW,   32'h0000_6000, 1'b1, 4'b0100, 2'd0},
            '{3'b100, mhq_pkg::LW,   32'h0000_6000, 1'b0, 4'b0001, 2'd1},
            '{3'b000, mhq_pkg::LW,   32'h0000_0000, 1'b1, 4'b0000, 2'd0},
            '{3'b000, mhq_pkg::LW,   32'h0000_0000, 1'b0, 4'b0000, 2'd0},
            '{3'b000, mhq_pkg::LW,   32'h0000_0000, 1'b1, 4'b0000, 2'd0},
            '{3'b000, mhq_pkg::LW,   32'h0000_0000, 1'b0, 4'b0000, 2'd0},
            '{3'b000, mhq_pkg::LW,   32'h0000_0000, 1'b1, 4'b0000, 2'd0},
            '{3'b000, mhq_pkg::LW,   32'h0000_0000, 1'b0, 4'b0000, 2'd0},
            '{3'b000, mhq_pkg::LW,   32'h0000_0000, 1'b1, 4'b0000, 2'd0},
            '{3'b000, mhq_pkg::LW,   32'h0000_0000, 1'b0, 4'b0000, 2'd0},
            '{3'b000, mhq_pkg::LW,   32'h0000_0000, 1'b0, 4'b0000, 2'd0}
        };
    endtask

    // Stores write from byte 0 of the data word upward
    function automatic logic [3:0] store_byte_sel(input mhq_pkg::lsu_func_t f);
        case (f)
            mhq_pkg::SB: return 4'b0001;
            mhq_pkg::SH: return 4'b0011;
            mhq_pkg::SW: return 4'b1111;
            default:     return 4'b0000;
        endcase
    endfunction

    function automatic logic [LINE_W-1:0] random_line();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic logic [LINE_W-1:0] overlay_stores(input logic [LINE_W-1:0] line,
                                                         input logic [LINE_W-1:0] stored,
                                                         input logic [15:0] mask);
        logic [LINE_W-1:0] result;
        result = line;
        for (int b = 0; b < 16; b++) begin
            if (mask[b]) begin
                result[b*8 +: 8] = stored[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_res(input mhq_pkg::lu_res_t got, input logic [TAG_W-1:0] got_tag,
                             input mhq_pkg::lu_res_t exp, input logic [TAG_W-1:0] exp_tag);
        if (got !== exp) begin
            $display("** Error o_lu_res got %h exp %h", got, exp);
            errors++;
        end
        // The tag only means something for an allocation or a match
        if ((exp.en || exp.match) && got_tag !== exp_tag) begin
            $display("** Error o_lu_tag got %h exp %h", got_tag, exp_tag);
            errors++;
        end
    endtask

    task automatic check_fill(input mhq_pkg::fill_t got, input mhq_pkg::fill_t exp);
        if (got.en !== exp.en) begin
            $display("** Error o_fill.en got %h exp %h", got.en, exp.en);
            errors++;
        end else if (exp.en && got.addr !== exp.addr) begin
            $display("** Error o_fill.addr got %h exp %h", got.addr, exp.addr);
            errors++;
        end else if (exp.en && got.data !== exp.data) begin
            $display("** Error o_fill.data got %h exp %h", got.data, exp.data);
            errors++;
        end
    endtask

    task automatic check_biu(input logic got_req, input logic [LA_W-1:0] got_addr,
                             input logic [LA_W-1:0] exp_addr);
        if (got_req !== 1'b1) begin
            $display("BIU request was not raised for line %h", exp_addr);
            errors++;
        end else if (got_addr !== exp_addr) begin
            $display("** Error o_biu_addr got %h exp %h", got_addr, exp_addr);
            errors++;
        end
    endtask

    // Drives one table row and updates the queue model from its expected result
    task automatic drive_step(input int idx);
        step_t             s;
        int                front;
        logic [LINE_W-1:0] line;
        logic [3:0]        sel;
        logic [3:0]        off;
        s = steps[idx];
        sel = store_byte_sel(s.func);
        off = s.addr[3:0];
        lu_req = '{valid: s.req[2], dc_hit: s.req[1], we: s.req[0], func: s.func,
                   addr: s.addr, data: $urandom()};
        exp_res = '{en: s.exp[0], we: s.req[0], match: s.exp[3], retry: s.exp[2],
                    replay: s.exp[1], addr: s.addr[31:4], offset: off,
                    byte_sel: sel, data: lu_req.data};
        exp_fill = '0;
        biu_rsp = '0;
        if (s.biu) begin
            front = alloc_q.pop_front();
            line = random_line();
            check_biu(biu_req, biu_addr, model_line[front]);
            biu_rsp = '{done: 1'b1, addr: model_line[front], data: line};
            exp_fill = '{en: 1'b1, addr: model_line[front],
                         data: overlay_stores(line, model_data[front], model_mask[front])};
        end
        if (s.exp[0] && !s.exp[3]) begin
            alloc_q.push_back(int'(s.tag));
            model_line[s.tag] = s.addr[31:4];
            model_mask[s.tag] = '0;
        end
        if (s.exp[0] && s.req[0]) begin
            for (int k = 0; k < 4; k++) begin
                if (sel[k]) begin
                    model_data[s.tag][(off + k)*8 +: 8] = lu_req.data[k*8 +: 8];
                    model_mask[s.tag][off + k] = 1'b1;
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        n_rst = 1'b0;
        lu_req = '0;
        biu_rsp = '0;
        errors = 0;
        failed_steps = 0;
        void'($urandom(32'h47e9_0d37));
        load_steps();
        repeat (5) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        for (int i = 0; i < NUM_STEPS; i++) begin
            errors_before = errors;
            drive_step(i);
            @(posedge clk);
            @(negedge clk);
            check_res(lu_res, lu_tag, exp_res, steps[i].tag);
            check_fill(fill, exp_fill);
            if (errors != errors_before) begin
                failed_steps++;
            end
            $display("step %0d: %s", i, (errors == errors_before) ? "ok" : "failed");
        end
        $display("steps %0d, failed steps %0d, errors %0d", NUM_STEPS, failed_steps, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Twenty cycles per table row is far more than any step needs
    initial begin
        #(NUM_STEPS * 20 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", NUM_STEPS * 20);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: mhq_assertions.sv
// ---------------------------------------------------------
// MHQ invariants on pointers, fill pulse and BIU request
// ---------------------------------------------------------
`timescale 1ns/1ps

module mhq_assertions #(
    parameter int  MHQ_DEPTH = 4,
    localparam int TAG_WIDTH = $clog2(MHQ_DEPTH)
) (
    input logic                  clk,
    input logic                  n_rst,
    input logic [TAG_WIDTH:0]    i_head_next,
    input logic [TAG_WIDTH:0]    i_tail_next,
    input mhq_pkg::lu_res_t      i_lu_res,
    input logic                  i_biu_req,
    input mhq_pkg::biu_rsp_t     i_biu_rsp,
    input mhq_pkg::fill_t        i_fill
);

    logic [TAG_WIDTH:0] occupancy;

    // The wrap bit keeps this difference valid across pointer wraps
    assign occupancy = i_tail_next - i_head_next;

    a_head_behind_tail: assert property (@(posedge clk) disable iff (!n_rst)
        occupancy <= (TAG_WIDTH + 1)'(MHQ_DEPTH))
        else $error("head pointer passed the tail pointer");

    a_fill_one_cycle: assert property (@(posedge clk) disable iff (!n_rst)
        i_fill.en |=> !i_fill.en)
        else $error("fill enable stayed high for more than one cycle");

    // A retried lookup saw a queue that was full for the following cycle
    a_retry_not_en: assert property (@(posedge clk) disable iff (!n_rst)
        i_lu_res.retry |-> (!i_lu_res.en &&
                            $past(occupancy) == (TAG_WIDTH + 1)'(MHQ_DEPTH)))
        else $error("lookup result has retry with enable or without a full queue");

    a_biu_req_hold: assert property (@(posedge clk) disable iff (!n_rst)
        (i_biu_req && !i_biu_rsp.done) |=> i_biu_req)
        else $error("BIU request dropped before done");

endmodule

bind mhq_top mhq_assertions #(.MHQ_DEPTH(MHQ_DEPTH)) mhq_assertions_i (
    .clk         (clk),
    .n_rst       (n_rst),
    .i_head_next (head_next),
    .i_tail_next (tail_next),
    .i_lu_res    (o_lu_res),
    .i_biu_req   (o_biu_req),
    .i_biu_rsp   (i_biu_rsp),
    .i_fill      (o_fill)
);

// File: mhq_top.sv
// ---------------------------------------------------------
// MHQ top level: lookup, execute, entry array and fill stage
// ---------------------------------------------------------
`timescale 1ns/1ps

module mhq_top #(
    parameter int  MHQ_DEPTH = 4,
    localparam int TAG_WIDTH = $clog2(MHQ_DEPTH)
) (
    input  logic                                clk,
    input  logic                                n_rst,
    input  mhq_pkg::lu_req_t                    i_lu_req,
    output mhq_pkg::lu_res_t                    o_lu_res,
    output logic [TAG_WIDTH-1:0]                o_lu_tag,
    output logic                                o_biu_req,
    output logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] o_biu_addr,
    input  mhq_pkg::biu_rsp_t                   i_biu_rsp,
    output mhq_pkg::fill_t                      o_fill
);

    logic [TAG_WIDTH:0]                  tail_next;
    logic [TAG_WIDTH:0]                  head_next;
    logic                                bypass_en;
    logic                                bypass_we;
    logic                                bypass_match;
    logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] bypass_addr;
    logic [TAG_WIDTH-1:0]                bypass_tag;
    mhq_pkg::entry_wr_t                  entry_wr;
    logic [MHQ_DEPTH-1:0]                entry_we;
    logic [MHQ_DEPTH-1:0]                entry_alloc;
    logic [MHQ_DEPTH-1:0]                entry_clear;
    mhq_pkg::entry_state_t               entry_state [MHQ_DEPTH];
    logic                                pop;

    mhq_lu #(.MHQ_DEPTH(MHQ_DEPTH)) mhq_lu_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_lu_req       (i_lu_req),
        .i_tail_next    (tail_next),
        .i_head_next    (head_next),
        .i_entry_state  (entry_state),
        .i_bypass_en    (bypass_en),
        .i_bypass_we    (bypass_we),
        .i_bypass_match (bypass_match),
        .i_bypass_addr  (bypass_addr),
        .i_bypass_tag   (bypass_tag),
        .i_fill         (o_fill),
        .i_biu_rsp      (i_biu_rsp),
        .o_lu_res       (o_lu_res),
        .o_lu_tag       (o_lu_tag)
    );

    mhq_ex #(.MHQ_DEPTH(MHQ_DEPTH)) mhq_ex_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_lu_res       (o_lu_res),
        .i_lu_tag       (o_lu_tag),
        .i_pop          (pop),
        .o_tail_next    (tail_next),
        .o_head_next    (head_next),
        .o_bypass_en    (bypass_en),
        .o_bypass_we    (bypass_we),
        .o_bypass_match (bypass_match),
        .o_bypass_addr  (bypass_addr),
        .o_bypass_tag   (bypass_tag),
        .o_entry_wr     (entry_wr),
        .o_entry_we     (entry_we),
        .o_entry_alloc  (entry_alloc)
    );

    for (genvar g = 0; g < MHQ_DEPTH; g++) begin : g_entry
        // On a pop head_next is already one past the entry to free
        assign entry_clear[g] = pop & (head_next[TAG_WIDTH-1:0] == TAG_WIDTH'(g + 1));

        mhq_entry mhq_entry_i (
            .clk     (clk),
            .n_rst   (n_rst),
            .i_we    (entry_we[g]),
            .i_alloc (entry_alloc[g]),
            .i_clear (entry_clear[g]),
            .i_wr    (entry_wr),
            .o_state (entry_state[g])
        );
    end

    mhq_fill #(.MHQ_DEPTH(MHQ_DEPTH)) mhq_fill_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_head_next   (head_next),
        .i_entry_state (entry_state),
        .i_biu_rsp     (i_biu_rsp),
        .o_biu_req     (o_biu_req),
        .o_biu_addr    (o_biu_addr),
        .o_fill        (o_fill),
        .o_pop         (pop)
    );

endmodule

// File: mhq_fill.sv
// ---------------------------------------------------------
// MHQ fill stage: fetches the head line from the BIU, lays
// the merged stores over it and hands it out as a cache fill
// ---------------------------------------------------------
`timescale 1ns/1ps

module mhq_fill #(
    parameter int  MHQ_DEPTH = 4,
    localparam int TAG_WIDTH = $clog2(MHQ_DEPTH)
) (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic [TAG_WIDTH:0]                  i_head_next,
    input  mhq_pkg::entry_state_t               i_entry_state [MHQ_DEPTH],
    input  mhq_pkg::biu_rsp_t                   i_biu_rsp,
    output logic                                o_biu_req,
    output logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] o_biu_addr,
    output mhq_pkg::fill_t                      o_fill,
    output logic                                o_pop
);

    typedef enum logic {
        IDLE,
        WAIT
    } fill_state_t;

    fill_state_t                    state;
    logic [TAG_WIDTH-1:0]           head_idx;
    logic [TAG_WIDTH-1:0]           head;
    logic                           issue;
    logic                           fill_en;
    logic [mhq_pkg::LINE_WIDTH-1:0] line_buf;
    logic [mhq_pkg::LINE_WIDTH-1:0] fill_data;
    mhq_pkg::entry_state_t          head_entry;

    // During a pop head_next already points past the entry being drained
    assign head_idx   = i_head_next[TAG_WIDTH-1:0];
    assign issue      = (state == IDLE) & i_entry_state[head_idx].valid;
    assign head_entry = i_entry_state[head];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state     <= IDLE;
            o_biu_req <= 1'b0;
            fill_en   <= 1'b0;
        end else begin
            fill_en <= 1'b0;
            if (issue) begin
                state     <= WAIT;
                o_biu_req <= 1'b1;
            end else if ((state == WAIT) && i_biu_rsp.done) begin
                state     <= IDLE;
                o_biu_req <= 1'b0;
                fill_en   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            head       <= head_idx;
            o_biu_addr <= i_entry_state[head_idx].addr;
        end
        if ((state == WAIT) && i_biu_rsp.done) begin
            line_buf <= i_biu_rsp.data;
        end
    end

    // Overlay happens in the fill cycle so a store merged on the done cycle is kept
    always_comb begin
        for (int b = 0; b < mhq_pkg::LINE_SIZE; b++) begin
            if (head_entry.mask[b]) begin
                fill_data[b*8 +: 8] = head_entry.data[b*8 +: 8];
            end else begin
                fill_data[b*8 +: 8] = line_buf[b*8 +: 8];
            end
        end
    end

    assign o_fill = '{en: fill_en, addr: head_entry.addr, data: fill_data};
    assign o_pop  = fill_en;

endmodule

// File: mhq_ex.sv
// ---------------------------------------------------------
// MHQ execute stage: writes lookup results into the entries
// and keeps the head and tail pointers
// ---------------------------------------------------------
`timescale 1ns/1ps

module mhq_ex #(
    parameter int  MHQ_DEPTH = 4,
    localparam int TAG_WIDTH = $clog2(MHQ_DEPTH)
) (
    input  logic                                clk,
    input  logic                                n_rst,

    input  mhq_pkg::lu_res_t                    i_lu_res,
    input  logic [TAG_WIDTH-1:0]                i_lu_tag,
    input  logic                                i_pop,

    // Pointers carry an extra wrap bit to tell full from empty
    output logic [TAG_WIDTH:0]                  o_tail_next,
    output logic [TAG_WIDTH:0]                  o_head_next,

    output logic                                o_bypass_en,
    output logic                                o_bypass_we,
    output logic                                o_bypass_match,
    output logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] o_bypass_addr,
    output logic [TAG_WIDTH-1:0]                o_bypass_tag,

    output mhq_pkg::entry_wr_t                  o_entry_wr,
    output logic [MHQ_DEPTH-1:0]                o_entry_we,
    output logic [MHQ_DEPTH-1:0]                o_entry_alloc
);

    logic [TAG_WIDTH:0] head;
    logic [TAG_WIDTH:0] tail;
    logic               alloc;

    // A miss without a match claims the tail entry
    assign alloc = i_lu_res.en & ~i_lu_res.match;

    assign o_tail_next = tail + {{TAG_WIDTH{1'b0}}, alloc};
    assign o_head_next = head + {{TAG_WIDTH{1'b0}}, i_pop};

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            head <= o_head_next;
            tail <= o_tail_next;
        end
    end

    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            o_entry_we[i]    = i_lu_res.en & (i_lu_tag == TAG_WIDTH'(i));
            o_entry_alloc[i] = alloc & (i_lu_tag == TAG_WIDTH'(i));
        end
    end

    assign o_entry_wr = '{addr:     i_lu_res.addr,
                          offset:   i_lu_res.offset,
                          byte_sel: i_lu_res.byte_sel,
                          data:     i_lu_res.data,
                          we:       i_lu_res.we};

    // Lookup sees this write one cycle before the entry shows it
    assign o_bypass_en    = alloc;
    assign o_bypass_we    = i_lu_res.en & i_lu_res.we;
    assign o_bypass_match = i_lu_res.en & i_lu_res.match;
    assign o_bypass_addr  = i_lu_res.addr;
    assign o_bypass_tag   = i_lu_tag;

endmodule

// File: mhq_lu.sv
// ---------------------------------------------------------
// MHQ lookup stage: matches the line against the queue and
// the execute bypass, picks a tag and flags retry or replay
// ---------------------------------------------------------
`timescale 1ns/1ps

module mhq_lu #(
    parameter int  MHQ_DEPTH = 4,
    localparam int TAG_WIDTH = $clog2(MHQ_DEPTH)
) (
    input  logic                                  clk,
    input  logic                                  n_rst,

    input  mhq_pkg::lu_req_t                      i_lu_req,

    // Pointers as they will stand next cycle
    input  logic [TAG_WIDTH:0]                    i_tail_next,
    input  logic [TAG_WIDTH:0]                    i_head_next,

    input  mhq_pkg::entry_state_t                 i_entry_state [MHQ_DEPTH],

    // Write in flight in the execute stage
    input  logic                                  i_bypass_en,
    input  logic                                  i_bypass_we,
    input  logic                                  i_bypass_match,
    input  logic [mhq_pkg::LINE_ADDR_WIDTH-1:0]   i_bypass_addr,
    input  logic [TAG_WIDTH-1:0]                  i_bypass_tag,

    // Fills seen for conflict checks
    input  mhq_pkg::fill_t                        i_fill,
    input  mhq_pkg::biu_rsp_t                     i_biu_rsp,

    output mhq_pkg::lu_res_t                      o_lu_res,
    output logic [TAG_WIDTH-1:0]                  o_lu_tag
);

    logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] req_line;
    logic [mhq_pkg::OFFSET_WIDTH-1:0]    req_offset;
    logic                                full_next;
    logic                                bypass_live;
    logic                                bypass_hit;
    logic [MHQ_DEPTH-1:0]                entry_hit;
    logic [TAG_WIDTH-1:0]                match_tag;
    logic                                match;
    logic [TAG_WIDTH-1:0]                tag;
    logic                                is_fill;
    logic                                retry;
    logic                                replay;
    logic                                en;
    logic [mhq_pkg::DATA_SIZE-1:0]       byte_sel;
    mhq_pkg::lu_res_t                    res_d;

    assign req_line   = i_lu_req.addr[mhq_pkg::ADDR_WIDTH-1:mhq_pkg::OFFSET_WIDTH];
    assign req_offset = i_lu_req.addr[mhq_pkg::OFFSET_WIDTH-1:0];

    // Full when the tail sits one wrap ahead of the head
    assign full_next = (i_tail_next == {~i_head_next[TAG_WIDTH], i_head_next[TAG_WIDTH-1:0]});

    // An allocation or a store merge one stage ahead is not in the array yet
    assign bypass_live = i_bypass_en | (i_bypass_we & i_bypass_match);
    assign bypass_hit  = bypass_live & (i_bypass_addr == req_line);

    always_comb begin
        match_tag = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            entry_hit[i] = i_entry_state[i].valid & (i_entry_state[i].addr == req_line);
            if (entry_hit[i]) begin
                match_tag = TAG_WIDTH'(i);
            end
        end
    end

    assign match = i_lu_req.valid & (bypass_hit | (|entry_hit));

    // The bypass is newer than the array, a new line goes to the tail
    assign tag = bypass_hit   ? i_bypass_tag :
                 (|entry_hit) ? match_tag    : i_tail_next[TAG_WIDTH-1:0];

    // A lookup racing a fill of its own line could land in an entry
    // that is being freed, so it is sent back to the LSU instead
    assign replay = i_lu_req.valid &
                    ((i_biu_rsp.done & (i_biu_rsp.addr == req_line)) |
                     (i_fill.en & (i_fill.addr == req_line)));

    assign retry   = i_lu_req.valid & full_next & ~match;
    assign is_fill = (i_lu_req.func == mhq_pkg::FILL);
    assign en      = i_lu_req.valid & ~i_lu_req.dc_hit & ~is_fill & ~retry & ~replay;

    always_comb begin
        case (i_lu_req.func)
            mhq_pkg::SB: byte_sel = 4'b0001;
            mhq_pkg::SH: byte_sel = 4'b0011;
            mhq_pkg::SW: byte_sel = 4'b1111;
            default:     byte_sel = 4'b0000;
        endcase
    end

    always_comb begin
        res_d.en       = en;
        res_d.we       = i_lu_req.we;
        res_d.match    = match;
        res_d.retry    = retry;
        res_d.replay   = replay;
        res_d.addr     = req_line;
        res_d.offset   = req_offset;
        res_d.byte_sel = byte_sel;
        res_d.data     = i_lu_req.data;
    end

    // Only the enable is cleared by reset
    always_ff @(posedge clk) begin
        o_lu_res <= res_d;
        o_lu_tag <= tag;
        if (!n_rst) begin
            o_lu_res.en <= 1'b0;
        end
    end

endmodule

// File: mhq_entry.sv
// ---------------------------------------------------------
// One MHQ entry: an outstanding line with merged store bytes
// ---------------------------------------------------------
`timescale 1ns/1ps

module mhq_entry (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  i_we,
    input  logic                  i_alloc,
    input  logic                  i_clear,
    input  mhq_pkg::entry_wr_t    i_wr,
    output mhq_pkg::entry_state_t o_state
);

    localparam int LINE_W = mhq_pkg::LINE_WIDTH;
    localparam int LINE_B = mhq_pkg::LINE_SIZE;

    logic [LINE_B-1:0] wr_mask;
    logic [LINE_W-1:0] wr_data;
    logic [LINE_B-1:0] base_mask;
    logic [LINE_W-1:0] merged_data;

    // Move the store word and its byte select to the line offset
    assign wr_mask = (i_we & i_wr.we) ? (LINE_B'(i_wr.byte_sel) << i_wr.offset) : '0;
    assign wr_data = LINE_W'(i_wr.data) << {i_wr.offset, 3'b000};

    // A fresh allocation starts with no merged bytes
    assign base_mask = i_alloc ? '0 : o_state.mask;

    always_comb begin
        for (int b = 0; b < LINE_B; b++) begin
            if (wr_mask[b]) begin
                merged_data[b*8 +: 8] = wr_data[b*8 +: 8];
            end else begin
                merged_data[b*8 +: 8] = o_state.data[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc) begin
            o_state.addr <= i_wr.addr;
        end
        o_state.data <= merged_data;
        o_state.mask <= base_mask | wr_mask;

        // Allocation wins over a clear in the same cycle
        if (!n_rst) begin
            o_state.valid <= 1'b0;
        end else if (i_alloc) begin
            o_state.valid <= 1'b1;
        end else if (i_clear) begin
            o_state.valid <= 1'b0;
        end
    end

endmodule

// File: mhq_pkg.sv
// ---------------------------------------------------------
// Miss handling queue shared widths, LSU function encoding
// and the packed structs passed between the queue stages
// ---------------------------------------------------------

package mhq_pkg;

    // Address and line geometry
    localparam int ADDR_WIDTH      = 32;
    localparam int DATA_WIDTH      = 32;
    localparam int LINE_SIZE       = 16;
    localparam int OFFSET_WIDTH    = $clog2(LINE_SIZE);
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;
    localparam int DATA_SIZE       = DATA_WIDTH / 8;
    localparam int LINE_WIDTH      = LINE_SIZE * 8;

    typedef enum logic [2:0] {
        LB   = 3'b000,
        LH   = 3'b001,
        LW   = 3'b010,
        SB   = 3'b011,
        SH   = 3'b100,
        SW   = 3'b101,
        FILL = 3'b110
    } lsu_func_t;

    // One LSU miss request per cycle
    typedef struct packed {
        logic                  valid;
        logic                  dc_hit;
        logic                  we;
        lsu_func_t             func;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } lu_req_t;

    // Registered lookup result, the tag travels beside it
    typedef struct packed {
        logic                       en;
        logic                       we;
        logic                       match;
        logic                       retry;
        logic                       replay;
        logic [LINE_ADDR_WIDTH-1:0] addr;
        logic [OFFSET_WIDTH-1:0]    offset;
        logic [DATA_SIZE-1:0]       byte_sel;
        logic [DATA_WIDTH-1:0]      data;
    } lu_res_t;

    typedef struct packed {
        logic [LINE_ADDR_WIDTH-1:0] addr;
        logic [OFFSET_WIDTH-1:0]    offset;
        logic [DATA_SIZE-1:0]       byte_sel;
        logic [DATA_WIDTH-1:0]      data;
        logic                       we;
    } entry_wr_t;

    // Mask bits mark the bytes written by merged stores
    typedef struct packed {
        logic                       valid;
        logic [LINE_ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0]      data;
        logic [LINE_SIZE-1:0]       mask;
    } entry_state_t;

    typedef struct packed {
        logic                       done;
        logic [LINE_ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0]      data;
    } biu_rsp_t;

    typedef struct packed {
        logic                       en;
        logic [LINE_ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0]      data;
    } fill_t;

endpackage
